// ==== files.f ====
+incdir+src
src/hid_pkg.sv
src/hid_byte_if.sv
src/hid_host_link.sv
src/c64_keymap.sv
src/key_matrix.sv
src/joy_slot.sv
src/hid_top.sv
tests/tb_hid.sv

// ==== tests/tb_hid.sv ====
// testbench for the hid block, sends controller byte streams and checks the outputs with assertions
`timescale 1ns/1ps
`include "hid_settings.svh"

module tb_hid;

  // bytes sent by all tests, start bytes included
  localparam int total_bytes     = 39;
  localparam int watchdog_cycles = total_bytes * 10;

  logic       clk;
  logic       reset;
  logic       data_in_strobe;
  logic       data_in_start;
  logic [7:0] data_in;
  logic [7:0] data_out;
  logic [5:0] db9_port;
  logic       irq;
  logic       iack;
  logic [1:0] shift_mod;
  logic [7:0] joystick0;
  logic [7:0] joystick1;
  logic [7:0] numpad;
  logic [7:0] keyboard_matrix_out;
  logic [7:0] keyboard_matrix_in;
  logic       key_restore;
  logic       tape_play;
  logic       mod_key;
  logic [1:0] mouse_btns;
  logic [7:0] mouse_x;
  logic [7:0] mouse_y;
  logic       mouse_strobe;
  logic [7:0] joystick0ax;
  logic [7:0] joystick0ay;
  logic [7:0] joystick1ax;
  logic [7:0] joystick1ay;
  logic       joystick_strobe;
  logic [7:0] extra_button0;
  logic [7:0] extra_button1;

  logic [31:0] lfsr_state;
  logic [7:0]  rnd;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_bad;

  // expected values and check enables, written by the stimulus
  logic        dout_check;
  logic [7:0]  exp_dout;
  logic        mark_mouse;
  logic [1:0]  exp_btns;
  logic [7:0]  exp_mouse_x;
  logic [7:0]  exp_mouse_y;
  logic        mark_joy;
  logic [1:0]  joy_check;
  logic [31:0] exp_joy [2];
  logic        a_down;
  logic [7:0]  exp_scan;
  logic [7:0]  exp_numpad;
  logic        db9_kick;
  logic        irq_quiet;

  hid_top hid_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // only key A is ever pressed, it sits in column 1, row 2
  assign exp_scan = (a_down && !keyboard_matrix_out[1]) ? 8'hfb : 8'hff;

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
    errors++;
  endtask

  task automatic timing_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  reply_value: assert property (@(posedge clk) disable iff (reset)
    dout_check |-> data_out == exp_dout)
    else value_error("data_out", $sampled(data_out), exp_dout);

  mouse_pulse: assert property (@(posedge clk) disable iff (reset)
    mark_mouse |-> ##2 mouse_strobe ##1 !mouse_strobe)
    else timing_error("mouse_strobe missed its single pulse two cycles after the last byte");
  mouse_cause: assert property (@(posedge clk) disable iff (reset)
    mouse_strobe |-> $past(mark_mouse, 2))
    else timing_error("mouse_strobe pulsed without a finished mouse report");
  mouse_btns_value: assert property (@(posedge clk) disable iff (reset)
    mouse_strobe |-> mouse_btns == exp_btns)
    else value_error("mouse_btns", $sampled(mouse_btns), exp_btns);
  mouse_x_value: assert property (@(posedge clk) disable iff (reset)
    mouse_strobe |-> mouse_x == exp_mouse_x)
    else value_error("mouse_x", $sampled(mouse_x), exp_mouse_x);
  mouse_y_value: assert property (@(posedge clk) disable iff (reset)
    mouse_strobe |-> mouse_y == exp_mouse_y)
    else value_error("mouse_y", $sampled(mouse_y), exp_mouse_y);

  joy_pulse: assert property (@(posedge clk) disable iff (reset)
    mark_joy |-> ##2 joystick_strobe ##1 !joystick_strobe)
    else timing_error("joystick_strobe missed its single pulse after a report");
  joy_cause: assert property (@(posedge clk) disable iff (reset)
    joystick_strobe |-> $past(mark_joy, 2))
    else timing_error("joystick_strobe pulsed for a report no slot owns");
  joy0_value: assert property (@(posedge clk) disable iff (reset)
    joy_check[0] |-> {joystick0, joystick0ax, joystick0ay, extra_button0} == exp_joy[0])
    else value_error("joystick0 report",
                     $sampled({joystick0, joystick0ax, joystick0ay, extra_button0}), exp_joy[0]);
  joy1_value: assert property (@(posedge clk) disable iff (reset)
    joy_check[1] |-> {joystick1, joystick1ax, joystick1ay, extra_button1} == exp_joy[1])
    else value_error("joystick1 report",
                     $sampled({joystick1, joystick1ax, joystick1ay, extra_button1}), exp_joy[1]);

  scan_value: assert property (@(posedge clk) disable iff (reset)
    keyboard_matrix_in == exp_scan)
    else value_error("keyboard_matrix_in", $sampled(keyboard_matrix_in), $sampled(exp_scan));
  scan_idle: assert property (@(posedge clk) disable iff (reset)
    (&keyboard_matrix_out) |-> keyboard_matrix_in == 8'hff)
    else value_error("keyboard_matrix_in", $sampled(keyboard_matrix_in), 8'hff);

  numpad_value: assert property (@(posedge clk) disable iff (reset)
    numpad == exp_numpad)
    else value_error("numpad", $sampled(numpad), exp_numpad);
  flags_value: assert property (@(posedge clk) disable iff (reset)
    {tape_play, key_restore, mod_key} == exp_numpad[7:5])
    else value_error("tape_play, key_restore, mod_key",
                     $sampled({tape_play, key_restore, mod_key}), exp_numpad[7:5]);

  irq_rise: assert property (@(posedge clk) disable iff (reset)
    db9_kick |-> ##[1:4] irq)
    else timing_error("irq did not rise within four cycles of an armed db9 change");
  irq_clear: assert property (@(posedge clk) disable iff (reset)
    (iack && irq) |=> !irq)
    else timing_error("iack did not clear irq on the next edge");
  irq_low: assert property (@(posedge clk) disable iff (reset)
    irq_quiet |-> !irq)
    else value_error("irq", $sampled(irq), 1'b0);

  // galois lfsr, one step per bit handed out
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = 8'h00;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'ha300_0000;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      r = {r[6:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // one strobe then one idle cycle, returns two falling edges later
  task automatic send_byte(input logic start, input logic [7:0] value);
    data_in_start  = start;
    data_in        = value;
    data_in_strobe = 1'b1;
    @(negedge clk);
    data_in_strobe = 1'b0;
    data_in_start  = 1'b0;
    mark_mouse     = 1'b0;
    mark_joy       = 1'b0;
    @(negedge clk);
  endtask

  task automatic expect_reply(input logic [7:0] value);
    exp_dout   = value;
    dout_check = 1'b1;
    @(negedge clk);
    dout_check = 1'b0;
  endtask

  task automatic send_key(input logic [7:0] code);
    send_byte(1'b1, `HID_CMD_KEY);
    send_byte(1'b0, code);
  endtask

  task automatic await_high(input string name);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 8) begin
      case (name)
        "mouse_strobe":    seen = mouse_strobe;
        "joystick_strobe": seen = joystick_strobe;
        default:           seen = irq;
      endcase
      if (!seen) begin
        @(negedge clk);
        n++;
      end
    end
    if (!seen) begin
      timing_error({"timed out waiting for ", name});
    end
  endtask

  task automatic send_joy(input logic [7:0] device);
    logic [31:0] report;
    logic        owned;
    report = '0;
    owned  = device < `HID_NUM_JOY;
    for (int i = 0; i < 4; i++) begin
      report = {report[23:0], rand_bits(8)};
    end
    if (owned) begin
      joy_check[device[0]] = 1'b0;
    end
    send_byte(1'b1, `HID_CMD_JOY);
    send_byte(1'b0, device);
    for (int i = 0; i < 3; i++) begin
      send_byte(1'b0, report[31-8*i -: 8]);
    end
    mark_joy = owned;
    send_byte(1'b0, report[7:0]);
    if (owned) begin
      await_high("joystick_strobe");
      exp_joy[device[0]]   = report;
      joy_check[device[0]] = 1'b1;
    end else begin
      repeat (4) @(negedge clk);
    end
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  // a few spare cycles let pending assertion attempts finish
  task automatic end_test(input string name);
    repeat (3) @(negedge clk);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - errors_at_start);
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    lfsr_state = 32'hc95f;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    reset = 1'b1;
    data_in_strobe = 1'b0;
    data_in_start = 1'b0;
    data_in = 8'h00;
    iack = 1'b0;
    shift_mod = 2'b00;
    keyboard_matrix_out = 8'hff;
    dout_check = 1'b0;
    exp_dout = 8'h00;
    mark_mouse = 1'b0;
    mark_joy = 1'b0;
    joy_check = 2'b00;
    a_down = 1'b0;
    exp_numpad = 8'h00;
    db9_kick = 1'b0;
    irq_quiet = 1'b1;
    rnd = rand_bits(6);
    db9_port = rnd[5:0];
    repeat (4) @(negedge clk);
    reset = 1'b0;

    begin_test();
    send_byte(1'b1, `HID_CMD_STATUS);
    send_byte(1'b0, 8'h00);
    expect_reply(8'h01);
    send_byte(1'b0, 8'h00);
    expect_reply(8'h00);
    end_test("status");

    begin_test();
    rnd = rand_bits(8);
    exp_btns = rnd[1:0];
    exp_mouse_x = rand_bits(8);
    exp_mouse_y = rand_bits(8);
    send_byte(1'b1, `HID_CMD_MOUSE);
    send_byte(1'b0, rnd);
    send_byte(1'b0, exp_mouse_x);
    mark_mouse = 1'b1;
    send_byte(1'b0, exp_mouse_y);
    await_high("mouse_strobe");
    end_test("mouse");

    begin_test();
    send_joy(8'd0);
    send_joy(8'd1);
    // no slot owns device 2, both reports must hold
    send_joy(8'd2);
    end_test("joystick");

    begin_test();
    send_key(8'h04);
    a_down = 1'b1;
    @(negedge clk);
    keyboard_matrix_out = 8'hfd;
    repeat (2) @(negedge clk);
    send_key(8'h84);
    a_down = 1'b0;
    repeat (2) @(negedge clk);
    keyboard_matrix_out = 8'hff;
    end_test("keyboard");

    begin_test();
    send_key(8'he3);
    exp_numpad = 8'h20;
    send_key(8'hc4);
    exp_numpad = 8'h60;
    send_key(8'hcb);
    exp_numpad = 8'he0;
    send_key(8'h85);
    exp_numpad = 8'h00;
    end_test("numpad");

    begin_test();
    irq_quiet = 1'b0;
    send_byte(1'b1, `HID_CMD_DB9);
    send_byte(1'b0, 8'h00);
    expect_reply({2'b00, db9_port});
    rnd = rand_bits(6);
    db9_port = db9_port ^ (rnd[5:0] | 6'h01);
    db9_kick = 1'b1;
    @(negedge clk);
    db9_kick = 1'b0;
    await_high("irq");
    iack = 1'b1;
    @(negedge clk);
    iack = 1'b0;
    @(negedge clk);
    // interrupt is now disarmed, another change must stay silent
    irq_quiet = 1'b1;
    rnd = rand_bits(6);
    db9_port = db9_port ^ (rnd[5:0] | 6'h01);
    repeat (6) @(negedge clk);
    end_test("db9 interrupt");

    $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== src/hid_top.sv ====
// hid block top for the c64 core, connects the controller stream to keyboard, mouse and joysticks
`timescale 1ns/1ps
`include "hid_settings.svh"

module hid_top
  import hid_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       data_in_strobe,
  input  logic                       data_in_start,
  input  logic [7:0]                 data_in,
  output logic [7:0]                 data_out,
  input  logic [5:0]                 db9_port,
  output logic                       irq,
  input  logic                       iack,
  input  logic [1:0]                 shift_mod,
  output logic [7:0]                 joystick0,
  output logic [7:0]                 joystick1,
  output logic [7:0]                 numpad,
  input  logic [`HID_MATRIX_DIM-1:0] keyboard_matrix_out,
  output logic [`HID_MATRIX_DIM-1:0] keyboard_matrix_in,
  output logic                       key_restore,
  output logic                       tape_play,
  output logic                       mod_key,
  output logic [1:0]                 mouse_btns,
  output logic [7:0]                 mouse_x,
  output logic [7:0]                 mouse_y,
  output logic                       mouse_strobe,
  output logic [7:0]                 joystick0ax,
  output logic [7:0]                 joystick0ay,
  output logic [7:0]                 joystick1ax,
  output logic [7:0]                 joystick1ay,
  output logic                       joystick_strobe,
  output logic [7:0]                 extra_button0,
  output logic [7:0]                 extra_button1
);

  hid_byte_if bus_if ();

  joy_report_t             joy_report [`HID_NUM_JOY];
  logic [`HID_NUM_JOY-1:0] joy_strobe;

  hid_host_link host_link_inst (
    .clk           (clk),
    .reset         (reset),
    .data_in_strobe(data_in_strobe),
    .data_in_start (data_in_start),
    .data_in       (data_in),
    .data_out      (data_out),
    .db9_port      (db9_port),
    .iack          (iack),
    .irq           (irq),
    .mouse_btns    (mouse_btns),
    .mouse_x       (mouse_x),
    .mouse_y       (mouse_y),
    .mouse_strobe  (mouse_strobe),
    .bus           (bus_if.src)
  );

  key_matrix key_matrix_inst (
    .clk                (clk),
    .reset              (reset),
    .bus                (bus_if.sink),
    .shift_mod          (shift_mod),
    .keyboard_matrix_out(keyboard_matrix_out),
    .keyboard_matrix_in (keyboard_matrix_in),
    .numpad             (numpad),
    .mod_key            (mod_key),
    .key_restore        (key_restore),
    .tape_play          (tape_play)
  );

  for (genvar i = 0; i < `HID_NUM_JOY; i++) begin : g_joy
    joy_slot #(
      .SLOT_ID(i)
    ) joy_slot_inst (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_if.sink),
      .report(joy_report[i]),
      .strobe(joy_strobe[i])
    );
  end

  // the core sees two fixed joystick ports
  assign joystick0     = joy_report[0].buttons;
  assign joystick0ax   = joy_report[0].ax;
  assign joystick0ay   = joy_report[0].ay;
  assign extra_button0 = joy_report[0].extra;
  assign joystick1     = joy_report[1].buttons;
  assign joystick1ax   = joy_report[1].ax;
  assign joystick1ay   = joy_report[1].ay;
  assign extra_button1 = joy_report[1].extra;

  assign joystick_strobe = |joy_strobe;

endmodule

// ==== src/joy_slot.sv ====
// one joystick report slot, filled from joystick commands addressed to its device number
`timescale 1ns/1ps
`include "hid_settings.svh"

module joy_slot
  import hid_pkg::*;
#(
  parameter int SLOT_ID = 0
) (
  input  logic        clk,
  input  logic        reset,
  hid_byte_if.sink    bus,
  output joy_report_t report,
  output logic        strobe
);

  logic       joy_evt;
  logic       match;
  logic [7:0] device;

  assign joy_evt = bus.stb && (bus.cmd == cmd_joy_in);

  // device byte decides once per command whether the rest is ours
  always_ff @(posedge clk) begin
    if (reset) begin
      match  <= 1'b0;
      strobe <= 1'b0;
    end else begin
      strobe <= joy_evt && match && (bus.idx == 4'd4);
      if (joy_evt && (bus.idx == 4'd0)) begin
        match <= (bus.data == 8'(SLOT_ID));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (joy_evt) begin
      if (bus.idx == 4'd0) begin
        device <= bus.data;
      end
      if (match) begin
        case (bus.idx)
          4'd1:    report.buttons <= bus.data;
          4'd2:    report.ax      <= bus.data;
          4'd3:    report.ay      <= bus.data;
          4'd4:    report.extra   <= bus.data;
          default: ;
        endcase
      end
    end
  end

  strobe_own_device: assert property (@(posedge clk) disable iff (reset)
    strobe |-> (device == 8'(SLOT_ID)));

endmodule

// ==== src/key_matrix.sv ====
// c64 keyboard matrix state built from key events, scanned by the cia column lines
`timescale 1ns/1ps
`include "hid_settings.svh"

module key_matrix
  import hid_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  hid_byte_if.sink                    bus,
  input  logic [1:0]                  shift_mod,
  input  logic [`HID_MATRIX_DIM-1:0]  keyboard_matrix_out,
  output logic [`HID_MATRIX_DIM-1:0]  keyboard_matrix_in,
  output logic [7:0]                  numpad,
  output logic                        mod_key,
  output logic                        key_restore,
  output logic                        tape_play
);

  // active low, a cleared bit is a pressed key
  logic [`HID_MATRIX_DIM-1:0] kbd   [`HID_MATRIX_DIM];
  logic [`HID_MATRIX_DIM-1:0] kbd_s [`HID_MATRIX_DIM];
  logic [2:0]                 row;
  logic [2:0]                 column;
  logic [2:0]                 row_s;
  logic [2:0]                 column_s;
  logic                       key_evt;
  logic                       np_hit;
  numpad_bit_e                np_sel;

  c64_keymap keymap_inst (
    .code     (bus.data[6:0]),
    .shift_mod(shift_mod),
    .row      (row),
    .column   (column),
    .row_s    (row_s),
    .column_s (column_s)
  );

  assign key_evt = bus.stb && (bus.cmd == cmd_key) && (bus.idx == 4'd0);

  // bit 7 of the key byte is the release flag
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < `HID_MATRIX_DIM; c++) begin
        kbd[c]   <= '1;
        kbd_s[c] <= '1;
      end
    end else if (key_evt) begin
      kbd[column][row]       <= bus.data[7];
      kbd_s[column_s][row_s] <= bus.data[7];
    end
  end

  // keypad keys that stand in for joystick and special c64 keys
  always_comb begin
    np_hit = 1'b1;
    case (bus.data[6:0])
      7'h5e:   np_sel = np_right;
      7'h5c:   np_sel = np_left;
      7'h5a:   np_sel = np_down;
      7'h60:   np_sel = np_up;
      7'h62:   np_sel = np_fire;
      7'h63:   np_sel = np_mod_key;
      7'h44:   np_sel = np_restore;
      7'h4b:   np_sel = np_tape_play;
      default: begin
        np_sel = np_right;
        np_hit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      numpad <= 8'h00;
    end else if (key_evt && bus.data[7]) begin
      if (np_hit) begin
        numpad[np_sel] <= 1'b1;
      end else begin
        numpad <= 8'h00;
      end
    end
  end

  assign mod_key     = numpad[np_mod_key];
  assign key_restore = numpad[np_restore];
  assign tape_play   = numpad[np_tape_play];

  // every column pulled low contributes its rows
  always_comb begin
    keyboard_matrix_in = '1;
    for (int c = 0; c < `HID_MATRIX_DIM; c++) begin
      if (!keyboard_matrix_out[c]) begin
        keyboard_matrix_in = keyboard_matrix_in & kbd[c] & kbd_s[c];
      end
    end
  end

  idle_scan_high: assert property (@(posedge clk) disable iff (reset)
    (&keyboard_matrix_out) |-> (keyboard_matrix_in == '1));

endmodule

// ==== src/c64_keymap.sv ====
// lookup from usb hid key code to c64 matrix column and row, with a shifted variant
`timescale 1ns/1ps

module c64_keymap (
  input  logic [6:0] code,
  input  logic [1:0] shift_mod,
  output logic [2:0] row,
  output logic [2:0] column,
  output logic [2:0] row_s,
  output logic [2:0] column_s
);

  // positions packed as {column, row}, written in octal
  logic [5:0] plain;
  logic [5:0] shifted;

  always_comb begin
    case (code)
      7'h04: plain = 6'o12;   // a
      7'h05: plain = 6'o34;   // b
      7'h06: plain = 6'o24;   // c
      7'h07: plain = 6'o22;   // d
      7'h08: plain = 6'o16;   // e
      7'h09: plain = 6'o25;   // f
      7'h0a: plain = 6'o32;   // g
      7'h0b: plain = 6'o35;   // h
      7'h0c: plain = 6'o41;   // i
      7'h0d: plain = 6'o42;   // j
      7'h0e: plain = 6'o45;   // k
      7'h0f: plain = 6'o52;   // l
      7'h10: plain = 6'o44;   // m
      7'h11: plain = 6'o47;   // n
      7'h12: plain = 6'o46;   // o
      7'h13: plain = 6'o51;   // p
      7'h14: plain = 6'o76;   // q
      7'h15: plain = 6'o21;   // r
      7'h16: plain = 6'o15;   // s
      7'h17: plain = 6'o26;   // t
      7'h18: plain = 6'o36;   // u
      7'h19: plain = 6'o37;   // v
      7'h1a: plain = 6'o11;   // w
      7'h1b: plain = 6'o27;   // x
      7'h1c: plain = 6'o31;   // y
      7'h1d: plain = 6'o14;   // z
      7'h1e: plain = 6'o70;   // 1
      7'h1f: plain = 6'o73;   // 2
      7'h20: plain = 6'o10;   // 3
      7'h21: plain = 6'o13;   // 4
      7'h22: plain = 6'o20;   // 5
      7'h23: plain = 6'o23;   // 6
      7'h24: plain = 6'o30;   // 7
      7'h25: plain = 6'o33;   // 8
      7'h26: plain = 6'o40;   // 9
      7'h27: plain = 6'o43;   // 0
      7'h28: plain = 6'o01;   // return
      7'h2a: plain = 6'o00;   // backspace onto inst/del
      7'h2c: plain = 6'o74;   // space
      7'h2d: plain = 6'o53;   // minus
      7'h2e: plain = 6'o65;   // equals
      7'h33: plain = 6'o62;   // semicolon
      default: plain = 6'o77; // run/stop
    endcase

    // with host shift held some symbols live on a different c64 key
    shifted = plain;
    if (shift_mod != 2'b00) begin
      case (code)
        7'h2e:   shifted = 6'o50;   // plus
        7'h33:   shifted = 6'o55;   // colon
        default: shifted = plain;
      endcase
    end
  end

  assign column   = plain[5:3];
  assign row      = plain[2:0];
  assign column_s = shifted[5:3];
  assign row_s    = shifted[2:0];

endmodule

// ==== src/hid_host_link.sv ====
// controller side of the hid block: command tracking, status and db9 replies, mouse capture
`timescale 1ns/1ps
`include "hid_settings.svh"

module hid_host_link
  import hid_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       data_in_strobe,
  input  logic       data_in_start,
  input  logic [7:0] data_in,
  output logic [7:0] data_out,
  input  logic [5:0] db9_port,
  input  logic       iack,
  output logic       irq,
  output logic [1:0] mouse_btns,
  output logic [7:0] mouse_x,
  output logic [7:0] mouse_y,
  output logic       mouse_strobe,
  hid_byte_if.src    bus
);

  hid_cmd_e   cmd_q;
  logic [3:0] idx_q;
  logic       payload_stb;
  logic [5:0] db9_s1;
  logic [5:0] db9_s2;
  logic       irq_arm;
  logic       mouse_evt;

  assign payload_stb = data_in_strobe & ~data_in_start;

  // start byte picks the command, each payload byte steps the index
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= cmd_status;
      idx_q <= 4'd0;
    end else if (data_in_strobe) begin
      if (data_in_start) begin
        cmd_q <= hid_cmd_e'(data_in);
        idx_q <= 4'd0;
      end else if (idx_q != 4'd15) begin
        idx_q <= idx_q + 4'd1;
      end
    end
  end

  // registered copy of each payload byte for the consumers
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.stb <= 1'b0;
    end else begin
      bus.stb <= payload_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (payload_stb) begin
      bus.cmd  <= cmd_q;
      bus.idx  <= idx_q;
      bus.data <= data_in;
    end
  end

  // replies to the controller, ready one cycle after the requesting byte
  always_ff @(posedge clk) begin
    if (payload_stb) begin
      if (cmd_q == cmd_status) begin
        if (idx_q == 4'd0) begin
          data_out <= 8'h01;
        end else if (idx_q == 4'd1) begin
          data_out <= 8'h00;
        end
      end else if (cmd_q == cmd_db9_out) begin
        data_out <= {2'b00, db9_s2};
      end
    end
  end

  // two stage synchronizer on the local joystick port
  always_ff @(posedge clk) begin
    db9_s1 <= db9_port;
    db9_s2 <= db9_s1;
  end

  // one interrupt per arm, the controller re-arms by reading the port
  always_ff @(posedge clk) begin
    if (reset) begin
      irq     <= 1'b0;
      irq_arm <= 1'b0;
    end else begin
      if (irq_arm && (db9_s1 != db9_s2)) begin
        irq     <= 1'b1;
        irq_arm <= 1'b0;
      end
      if (payload_stb && (cmd_q == cmd_db9_out) && (idx_q == 4'd0)) begin
        irq_arm <= 1'b1;
      end
      if (iack) begin
        irq <= 1'b0;
      end
    end
  end

  // mouse report is buttons, x, y
  assign mouse_evt = bus.stb && (bus.cmd == cmd_mouse);

  always_ff @(posedge clk) begin
    if (reset) begin
      mouse_strobe <= 1'b0;
    end else begin
      mouse_strobe <= mouse_evt && (bus.idx == 4'd2);
    end
  end

  always_ff @(posedge clk) begin
    if (mouse_evt) begin
      case (bus.idx)
        4'd0:    mouse_btns <= bus.data[1:0];
        4'd1:    mouse_x    <= bus.data;
        4'd2:    mouse_y    <= bus.data;
        default: ;
      endcase
    end
  end

  irq_needs_arm: assert property (@(posedge clk) disable iff (reset)
    $rose(irq) |-> $past(irq_arm));

endmodule

// ==== src/hid_byte_if.sv ====
// decoded payload byte stream from the command tracker to the keyboard and joystick blocks
`timescale 1ns/1ps

interface hid_byte_if
  import hid_pkg::*;
();

  // one-cycle pulse per payload byte, start bytes never show up here
  logic       stb;
  hid_cmd_e   cmd;
  // byte position in the payload, sticks at 15
  logic [3:0] idx;
  logic [7:0] data;

  modport src (
    output stb,
    output cmd,
    output idx,
    output data
  );

  modport sink (
    input stb,
    input cmd,
    input idx,
    input data
  );

endinterface

// ==== src/hid_pkg.sv ====
// shared hid types: command codes, joystick report layout and numpad flag positions
`include "hid_settings.svh"

package hid_pkg;

  // command selected by the start byte of each transfer
  typedef enum logic [7:0] {
    cmd_status  = `HID_CMD_STATUS,
    cmd_key     = `HID_CMD_KEY,
    cmd_mouse   = `HID_CMD_MOUSE,
    cmd_joy_in  = `HID_CMD_JOY,
    cmd_db9_out = `HID_CMD_DB9
  } hid_cmd_e;

  // one joystick report, in the order the payload bytes arrive
  typedef struct packed {
    logic [7:0] buttons;
    logic [7:0] ax;
    logic [7:0] ay;
    logic [7:0] extra;
  } joy_report_t;

  // numpad flag bits, low five are the keypad joystick keys
  typedef enum logic [2:0] {
    np_right     = 3'd0,
    np_left      = 3'd1,
    np_down      = 3'd2,
    np_up        = 3'd3,
    np_fire      = 3'd4,
    np_mod_key   = 3'd5,
    np_restore   = 3'd6,
    np_tape_play = 3'd7
  } numpad_bit_e;

endpackage

// ==== src/hid_settings.svh ====
// build constants for the hid block, included by the rtl and the testbench
`ifndef HID_SETTINGS_SVH
`define HID_SETTINGS_SVH

// joystick slots fed from the controller stream
`define HID_NUM_JOY 2

// c64 keyboard matrix is square, columns are driven and rows read back
`define HID_MATRIX_DIM 8

// command byte values sent with data_in_start
`define HID_CMD_STATUS 8'd0
`define HID_CMD_KEY    8'd1
`define HID_CMD_MOUSE  8'd2
`define HID_CMD_JOY    8'd3
`define HID_CMD_DB9    8'd4

`endif
